// File: Bender.yml
package:
  name: mcu_cmd

sources:
  - include_dirs:
      - common
    files:
      - common/mcu_cmd_pkg.sv
      - common/mem_bus_pkg.sv
      - logic/cfg_regs.sv
      - mem/mem_access.sv
      - logic/spi_reply.sv
      - logic/mcu_cmd_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/mcu_cmd_checker.sv
      - verif/mcu_cmd_tb.sv

// File: all.f
+incdir+common
common/mcu_cmd_pkg.sv
common/mem_bus_pkg.sv
logic/cfg_regs.sv
mem/mem_access.sv
logic/spi_reply.sv
logic/mcu_cmd_top.sv
verif/mcu_cmd_checker.sv
verif/mcu_cmd_tb.sv

// File: common/mcu_cmd_config.svh
`ifndef MCU_CMD_CONFIG_SVH
`define MCU_CMD_CONFIG_SVH

////////////////////////////////////////////////////////////
// widths fixed by the host protocol
////////////////////////////////////////////////////////////

// memory address pointer
`define MCU_ADDR_W 24
// one SPI byte
`define MCU_DATA_W 8
// byte position counter of the SPI link
`define MCU_BYTE_CNT_W 32
`define MCU_MAPPER_W 3

// reset and reply values
`define MCU_MAPPER_RST 3'd1
`define MCU_ID_BYTE 8'hA5

`endif

// File: common/mcu_cmd_pkg.sv
`include "mcu_cmd_config.svh"

package mcu_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // command classes, upper nibble of the command byte
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    CMD_SET_ADDR  = 4'h0,
    CMD_ROM_MASK  = 4'h1,
    CMD_SRAM_MASK = 4'h2,
    CMD_MAPPER    = 4'h3,
    CMD_MEM_READ  = 4'h8,
    CMD_MEM_WRITE = 4'h9,
    CMD_SYS       = 4'hF
  } cmd_class_e;

  // immediate replies
  localparam logic [`MCU_DATA_W-1:0] OP_ID   = {CMD_SYS, 4'h0};
  localparam logic [`MCU_DATA_W-1:0] OP_ECHO = {CMD_SYS, 4'hF};

  // byte positions, the command byte itself is number 1
  localparam logic [`MCU_BYTE_CNT_W-1:0] CNT_CMD = 1;
  localparam logic [`MCU_BYTE_CNT_W-1:0] CNT_HI  = 2;
  localparam logic [`MCU_BYTE_CNT_W-1:0] CNT_MID = 3;
  localparam logic [`MCU_BYTE_CNT_W-1:0] CNT_LO  = 4;

  // one received byte event
  typedef struct packed {
    logic                       is_cmd;
    logic                       is_param;
    logic [`MCU_DATA_W-1:0]     cmd;
    logic [`MCU_DATA_W-1:0]     data;
    logic [`MCU_BYTE_CNT_W-1:0] byte_cnt;
  } spi_byte_t;

  typedef struct packed {
    logic [`MCU_MAPPER_W-1:0] mapper;
    logic [`MCU_ADDR_W-1:0]   rom_mask;
    logic [`MCU_ADDR_W-1:0]   saveram_mask;
  } cfg_t;

  function automatic cmd_class_e cmd_class(input logic [`MCU_DATA_W-1:0] cmd);
    return cmd_class_e'(cmd[7:4]);
  endfunction

endpackage

// File: common/mem_bus_pkg.sv
`include "mcu_cmd_config.svh"

package mem_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Wishbone classic, single master to memory
  ////////////////////////////////////////////////////////////

  // master to slave
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`MCU_ADDR_W-1:0] adr;
    logic [`MCU_DATA_W-1:0] dat;
  } wb_req_t;

  // slave to master, dat only meaningful on a read ack
  typedef struct packed {
    logic                   ack;
    logic [`MCU_DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

// File: logic/cfg_regs.sv
`include "mcu_cmd_config.svh"

module cfg_regs
  import mcu_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  spi_byte_t spi_in,
  output cfg_t      cfg
);

  cmd_class_e cls;
  cfg_t       cfg_q;

  // insert one parameter byte into a 24-bit mask
  function automatic logic [`MCU_ADDR_W-1:0] mask_next(
    input logic [`MCU_ADDR_W-1:0]     old,
    input logic [`MCU_BYTE_CNT_W-1:0] cnt,
    input logic [`MCU_DATA_W-1:0]     data
  );
    logic [`MCU_ADDR_W-1:0] m;
    m = old;
    case (cnt)
      CNT_HI:  m[23:16] = data;
      CNT_MID: m[15:8]  = data;
      CNT_LO:  m[7:0]   = data;
      default: m = old;
    endcase
    return m;
  endfunction

  assign cls = cmd_class(spi_in.cmd);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_q.mapper       <= `MCU_MAPPER_RST;
      cfg_q.rom_mask     <= '0;
      cfg_q.saveram_mask <= '0;
    end else if (spi_in.is_cmd && cls == CMD_MAPPER) begin
      cfg_q.mapper <= spi_in.cmd[`MCU_MAPPER_W-1:0];
    end else if (spi_in.is_param && cls == CMD_ROM_MASK) begin
      cfg_q.rom_mask <= mask_next(cfg_q.rom_mask, spi_in.byte_cnt, spi_in.data);
    end else if (spi_in.is_param && cls == CMD_SRAM_MASK) begin
      cfg_q.saveram_mask <= mask_next(cfg_q.saveram_mask, spi_in.byte_cnt, spi_in.data);
    end
  end

  assign cfg = cfg_q;

endmodule

// File: logic/mcu_cmd_top.sv
`include "mcu_cmd_config.svh"

module mcu_cmd_top
  import mcu_cmd_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_byte_t              spi_in,
  input  wb_rsp_t                wb_rsp,
  output wb_req_t                wb_req,
  output cfg_t                   cfg,
  output logic [`MCU_DATA_W-1:0] spi_data_out
);

  logic [`MCU_DATA_W-1:0] rd_data;
  logic                   rd_valid;

  ////////////////////////////////////////////////////////////
  // configuration and memory side by side
  ////////////////////////////////////////////////////////////
  cfg_regs u_cfg_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .spi_in (spi_in),
    .cfg    (cfg)
  );

  mem_access u_mem_access (
    .clk      (clk),
    .rst_n    (rst_n),
    .spi_in   (spi_in),
    .wb_rsp   (wb_rsp),
    .wb_req   (wb_req),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  // reply byte back to the host
  spi_reply u_spi_reply (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_in       (spi_in),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .spi_data_out (spi_data_out)
  );

endmodule

// File: logic/spi_reply.sv
`include "mcu_cmd_config.svh"

module spi_reply
  import mcu_cmd_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_byte_t              spi_in,
  input  logic [`MCU_DATA_W-1:0] rd_data,
  input  logic                   rd_valid,
  output logic [`MCU_DATA_W-1:0] spi_data_out
);

  logic evt;

  assign evt = spi_in.is_cmd || spi_in.is_param;

  // next byte the host shifts out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      spi_data_out <= '0;
    end else if (rd_valid) begin
      spi_data_out <= rd_data;
    end else if (evt) begin
      if (spi_in.cmd == OP_ID) begin
        spi_data_out <= `MCU_ID_BYTE;
      end else if (spi_in.cmd == OP_ECHO && spi_in.is_param) begin
        // echo only real parameter bytes
        spi_data_out <= spi_in.data;
      end
    end
  end

endmodule

// File: mem/mem_access.sv
`include "mcu_cmd_config.svh"

module mem_access
  import mcu_cmd_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_byte_t              spi_in,
  input  wb_rsp_t                wb_rsp,
  output wb_req_t                wb_req,
  output logic [`MCU_DATA_W-1:0] rd_data,
  output logic                   rd_valid
);

  localparam int LOW_W = `MCU_ADDR_W - `MCU_DATA_W;

  cmd_class_e cls;
  logic       start_rd;
  logic       start_wr;
  logic       addr_ld;
  logic       ack;
  logic       inc_ok;

  logic                       cyc_q;
  logic                       we_q;
  logic [`MCU_ADDR_W-1:0]     addr_q;
  logic [`MCU_DATA_W-1:0]     dat_q;
  logic [`MCU_DATA_W-1:0]     cmd_q;
  logic [`MCU_BYTE_CNT_W-1:0] cnt_q;

  assign cls      = cmd_class(spi_in.cmd);
  assign start_rd = (spi_in.is_cmd || spi_in.is_param) && cls == CMD_MEM_READ;
  assign start_wr = spi_in.is_param && cls == CMD_MEM_WRITE;
  assign addr_ld  = spi_in.is_param && cls == CMD_SET_ADDR;
  assign ack      = cyc_q && wb_rsp.ack;

  // bit 3 enables increment, bit 4 skips it for the command byte
  assign inc_ok = cmd_q[3] &&
                  (cnt_q >= CNT_CMD + `MCU_BYTE_CNT_W'(cmd_q[4]));

  ////////////////////////////////////////////////////////////
  // bus FSM and address pointer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cyc_q    <= 1'b0;
      we_q     <= 1'b0;
      rd_valid <= 1'b0;
      addr_q   <= '0;
    end else begin
      rd_valid <= 1'b0;
      if (start_rd || start_wr) begin
        cyc_q <= 1'b1;
        we_q  <= start_wr;
      end else if (ack) begin
        cyc_q    <= 1'b0;
        rd_valid <= !we_q;
        if (inc_ok) begin
          addr_q <= addr_q + 1'b1;
        end
      end
      // never overlaps an access, the host waits for cyc to drop
      if (addr_ld) begin
        case (spi_in.byte_cnt)
          CNT_HI:  addr_q <= {spi_in.data, {LOW_W{1'b0}}};
          CNT_MID: addr_q[2*`MCU_DATA_W-1:`MCU_DATA_W] <= spi_in.data;
          CNT_LO:  addr_q[`MCU_DATA_W-1:0] <= spi_in.data;
          default: addr_q <= addr_q;
        endcase
      end
    end
  end

  // command context of the access in flight
  always_ff @(posedge clk) begin
    if (start_rd || start_wr) begin
      dat_q <= spi_in.data;
      cmd_q <= spi_in.cmd;
      cnt_q <= spi_in.byte_cnt;
    end
    if (ack && !we_q) begin
      rd_data <= wb_rsp.dat;
    end
  end

  always_comb begin
    wb_req.cyc = cyc_q;
    wb_req.stb = cyc_q;
    wb_req.we  = we_q;
    wb_req.adr = addr_q;
    wb_req.dat = dat_q;
  end

endmodule

// File: verif/mcu_cmd_checker.sv
module mcu_cmd_checker
  import mcu_cmd_pkg::*;
  import mem_bus_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input spi_byte_t spi_in,
  input wb_req_t   wb_req,
  input wb_rsp_t   wb_rsp
);

  ////////////////////////////////////////////////////////////
  // Wishbone classic handshake
  ////////////////////////////////////////////////////////////
  stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.stb |-> wb_req.cyc)
    else $error("stb is high while cyc is low");

  // request held through wait states
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.stb && !wb_rsp.ack |=>
      $stable(wb_req.adr) && $stable(wb_req.we) && $stable(wb_req.dat))
    else $error("adr, we or dat changed before the ack");

  // host waits for the access to finish
  no_event_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.cyc |-> !(spi_in.is_cmd || spi_in.is_param))
    else $error("SPI byte arrived while a memory access was pending");

  cyc_low_in_reset: assert property (@(posedge clk)
    !rst_n |=> !wb_req.cyc)
    else $error("cyc is high after a reset cycle");

endmodule

bind mcu_cmd_top mcu_cmd_checker u_mcu_cmd_checker (
  .clk    (clk),
  .rst_n  (rst_n),
  .spi_in (spi_in),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp)
);

// File: verif/mcu_cmd_tb.sv
`include "mcu_cmd_config.svh"

module mcu_cmd_tb
  import mcu_cmd_pkg::*;
  import mem_bus_pkg::*;
();

  localparam logic [31:0] SEED       = 32'd85512;
  localparam int          DRV        = 10;
  localparam int          ACK_DRV    = 5;
  localparam int          WAIT_LIMIT = 20;

  logic                   clk;
  logic                   rst_n;
  spi_byte_t              spi_in;
  wb_rsp_t                wb_rsp;
  wb_req_t                wb_req;
  cfg_t                   cfg;
  logic [`MCU_DATA_W-1:0] spi_data_out;

  logic [31:0]            stim_rng;
  logic [31:0]            slave_rng;
  cfg_t                   model_cfg;
  logic [`MCU_ADDR_W-1:0] model_addr;
  logic [`MCU_DATA_W-1:0] ram [logic [`MCU_ADDR_W-1:0]];
  logic [`MCU_DATA_W-1:0] exp_mem [logic [`MCU_ADDR_W-1:0]];

  mcu_cmd_top u_mcu_cmd_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_in       (spi_in),
    .wb_rsp       (wb_rsp),
    .wb_req       (wb_req),
    .cfg          (cfg),
    .spi_data_out (spi_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  // fill for unwritten memory mixes every address bit
  function automatic logic [7:0] fill_byte(input logic [`MCU_ADDR_W-1:0] a);
    return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h3c;
  endfunction

  // byte 2 is the top byte and byte 4 the low byte
  function automatic logic [`MCU_ADDR_W-1:0] put_byte(input logic [`MCU_ADDR_W-1:0] old,
                                                      input int pos, input logic [7:0] d);
    logic [`MCU_ADDR_W-1:0] v;
    v = old;
    case (pos)
      2: v[23:16] = d;
      3: v[15:8] = d;
      4: v[7:0] = d;
      default: v = old;
    endcase
    return v;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRV;
  endtask

  task automatic idle_gap();
    logic [31:0] r;
    r = next_rand();
    repeat (r % 3) next_cycle();
  endtask

  // drives a one-cycle byte event and returns one cycle later
  task automatic send_byte(input logic cmd_ev, input logic [7:0] cmd, input logic [7:0] data,
                           input logic [`MCU_BYTE_CNT_W-1:0] cnt);
    spi_in.is_cmd   = cmd_ev;
    spi_in.is_param = !cmd_ev;
    spi_in.cmd      = cmd;
    spi_in.data     = data;
    spi_in.byte_cnt = cnt;
    next_cycle();
    spi_in.is_cmd   = 1'b0;
    spi_in.is_param = 1'b0;
  endtask

  task automatic set_address(input logic [`MCU_ADDR_W-1:0] a);
    logic [31:0] r;
    logic [7:0]  cmd;
    logic [7:0]  d;
    r   = next_rand();
    cmd = {CMD_SET_ADDR, r[3:0]};
    send_byte(1'b1, cmd, r[15:8], 1);
    idle_gap();
    for (int i = 2; i <= 4; i++) begin
      d = a[(4-i)*8 +: 8];
      send_byte(1'b0, cmd, d, i);
      // top byte clears the rest
      model_addr = put_byte((i == 2) ? '0 : model_addr, i, d);
      idle_gap();
    end
  endtask

  // one read or write byte checked at its ack
  task automatic send_mem_byte(input logic cmd_ev, input logic [7:0] cmd,
                               input logic [7:0] data, input logic [`MCU_BYTE_CNT_W-1:0] cnt);
    int         n;
    logic       wr;
    logic [7:0] exp_rd;
    wr = (cmd[7:4] == CMD_MEM_WRITE);
    exp_rd = '0;
    send_byte(cmd_ev, cmd, data, cnt);
    n = 0;
    while (!wb_req.cyc) begin
      if (n >= WAIT_LIMIT) stop_with_error("no Wishbone request after a memory byte");
      next_cycle();
      n++;
    end
    n = 0;
    while (wb_req.cyc) begin
      if (wb_rsp.ack) begin
        check_value("wb_req.stb", wb_req.stb, 1'b1);
        check_value("wb_req.adr", wb_req.adr, model_addr);
        check_value("wb_req.we", wb_req.we, wr);
        if (wr) begin
          check_value("wb_req.dat", wb_req.dat, data);
          exp_mem[model_addr] = data;
        end else begin
          exp_rd = exp_mem.exists(model_addr) ? exp_mem[model_addr] : fill_byte(model_addr);
        end
      end
      if (n >= WAIT_LIMIT) stop_with_error("Wishbone access never completed");
      next_cycle();
      n++;
    end
    if (cmd[3] && cnt >= 1 + cmd[4]) model_addr = model_addr + 1'b1;
    if (!wr) begin
      next_cycle();
      check_value("spi_data_out", spi_data_out, exp_rd);
    end
    idle_gap();
  endtask

  ////////////////////////////////////////////////////////////
  // Wishbone slave memory with 0 to 3 wait cycles
  ////////////////////////////////////////////////////////////
  initial begin
    logic       busy;
    logic [1:0] wait_cnt;
    wb_rsp    = '0;
    slave_rng = SEED ^ 32'h9e3779b9;
    busy      = 1'b0;
    wait_cnt  = '0;
    forever begin
      @(posedge clk);
      #ACK_DRV;
      wb_rsp.ack = 1'b0;
      if (wb_req.cyc && wb_req.stb && rst_n) begin
        if (!busy) begin
          slave_rng = xorshift(slave_rng);
          wait_cnt  = slave_rng[1:0];
          busy      = 1'b1;
        end
        if (wait_cnt == 0) begin
          wb_rsp.ack = 1'b1;
          busy       = 1'b0;
          if (wb_req.we) begin
            ram[wb_req.adr] = wb_req.dat;
          end else begin
            wb_rsp.dat = ram.exists(wb_req.adr) ? ram[wb_req.adr] : fill_byte(wb_req.adr);
          end
        end else begin
          wait_cnt = wait_cnt - 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus and checks
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0]            r;
    logic [7:0]             cmd;
    logic [`MCU_ADDR_W-1:0] base;
    int                     len;
    stim_rng = SEED;
    spi_in   = '0;
    rst_n    = 1'b0;
    repeat (4) @(posedge clk);
    #DRV;
    rst_n = 1'b1;
    model_cfg.mapper       = `MCU_MAPPER_RST;
    model_cfg.rom_mask     = '0;
    model_cfg.saveram_mask = '0;
    model_addr             = '0;
    check_value("wb_req.cyc", wb_req.cyc, 1'b0);
    check_value("wb_req.stb", wb_req.stb, 1'b0);
    check_value("cfg", cfg, model_cfg);
    check_value("spi_data_out", spi_data_out, 8'h00);

    // mapper and mask loads
    repeat (12) begin
      r = next_rand();
      if (r[1:0] == 2'd0 || r[1:0] == 2'd3) begin
        cmd = {CMD_MAPPER, r[7:4]};
        send_byte(1'b1, cmd, r[15:8], 1);
        model_cfg.mapper = cmd[`MCU_MAPPER_W-1:0];
      end else begin
        cmd = {2'b00, r[1:0], r[7:4]};
        send_byte(1'b1, cmd, r[15:8], 1);
        for (int i = 2; i <= 4; i++) begin
          r = next_rand();
          send_byte(1'b0, cmd, r[7:0], i);
          if (cmd[7:4] == CMD_ROM_MASK) begin
            model_cfg.rom_mask = put_byte(model_cfg.rom_mask, i, r[7:0]);
          end else begin
            model_cfg.saveram_mask = put_byte(model_cfg.saveram_mask, i, r[7:0]);
          end
        end
      end
      check_value("cfg", cfg, model_cfg);
      idle_gap();
    end

    // write bursts and read back from the same start
    repeat (5) begin
      r    = next_rand();
      base = r[`MCU_ADDR_W-1:0];
      set_address(base);
      r   = next_rand();
      cmd = {CMD_MEM_WRITE, r[3:0]};
      len = 1 + (r[6:4] % 6);
      send_byte(1'b1, cmd, r[15:8], 1);
      idle_gap();
      for (int i = 2; i <= len + 1; i++) begin
        r = next_rand();
        send_mem_byte(1'b0, cmd, r[7:0], i);
      end
      set_address(base);
      r   = next_rand();
      cmd = {CMD_MEM_READ, r[3:0]};
      len = 1 + (r[6:4] % 6);
      send_mem_byte(1'b1, cmd, r[15:8], 1);
      for (int i = 2; i <= len; i++) begin
        r = next_rand();
        send_mem_byte(1'b0, cmd, r[7:0], i);
      end
    end

    // immediate replies
    r = next_rand();
    send_byte(1'b1, OP_ID, r[7:0], 1);
    check_value("spi_data_out", spi_data_out, `MCU_ID_BYTE);
    idle_gap();
    send_byte(1'b1, OP_ECHO, 8'h00, 1);
    idle_gap();
    for (int i = 2; i <= 9; i++) begin
      r = next_rand();
      send_byte(1'b0, OP_ECHO, r[7:0], i);
      check_value("spi_data_out", spi_data_out, r[7:0]);
      idle_gap();
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
